//--- mtx_params.svh
`ifndef MTX_PARAMS_SVH
`define MTX_PARAMS_SVH

// Datapath widths
`define MTX_DATA_W        16
`define MTX_PHASE_W       24
`define MTX_SYMB_W        8
`define MTX_GPIO_W        12
`define MTX_HOP_W         16
`define MTX_CNT_W         5

// Tone generator framing
`define MTX_NSIG          32          // Samples per symbol
`define MTX_NSYMB         4           // Symbols per frame
`define MTX_DPH_INC       24'h010000  // Step added per symbol
`define MTX_START_PH_INC  24'h040000  // Step of symbol 0

// Sequencer and scan timing
`define MTX_SYNC_LEN      40          // Cycles per sync phase
`define MTX_SCAN_DIV      4           // Cycles per scan half-phase

// Header pin map
`define MTX_SYNC_MASK     12'h001
`define MTX_LOAD_MASK     12'h004
`define MTX_DATA_MASK     12'h010
`define MTX_PHIB_MASK     12'h040
`define MTX_PHI_MASK      12'h100
`define MTX_ID_MASK       12'h400
`define MTX_TX_MASK       12'h800
`define MTX_IN_MASK       12'h022

`endif

//--- mtx_pkg.sv
`default_nettype none

`include "mtx_params.svh"

package mtx_pkg;

  // I/Q sample, two's complement
  typedef logic signed [`MTX_DATA_W-1:0] sample_t;

  typedef logic [`MTX_PHASE_W-1:0] phase_t;

  typedef logic [`MTX_SYMB_W-1:0] symb_t;

  // One word per header pin
  typedef logic [`MTX_GPIO_W-1:0] gpio_t;

  typedef logic [`MTX_HOP_W-1:0] hop_word_t;

  typedef logic [`MTX_CNT_W-1:0] bit_cnt_t;

  // Burst sequencer, four sync phases then continuous transmission
  typedef enum logic [2:0] {
    SEQ_LEAD,
    SEQ_MARK,
    SEQ_BLANK,
    SEQ_TAIL,
    SEQ_RUN
  } seq_state_t;

endpackage

`default_nettype wire

//--- scan_if.sv
`timescale 1ns/1ns
`default_nettype none

// Lines of the scan chain into the RF chip
interface scan_if;

  logic scan_id;   // Chain select, high while bits shift
  logic phi;       // First phase clock
  logic phi_bar;   // Second phase clock, never overlaps phi
  logic data;      // Serial data, MSB first
  logic load;      // Latch strobe after the last bit

  modport driver (
    output scan_id,
    output phi,
    output phi_bar,
    output data,
    output load
  );

  modport pins (
    input scan_id,
    input phi,
    input phi_bar,
    input data,
    input load
  );

endinterface

`default_nettype wire

//--- mtx_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mtx_params.svh"

module mtx_ctrl (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  frame_done,
  output logic                 gen_hold,
  output logic                 hop_hold,
  output logic                 blank,
  output logic                 sync_level,
  output mtx_pkg::seq_state_t  state
);

  import mtx_pkg::*;

  localparam int CNT_W = $clog2(`MTX_SYNC_LEN);

  logic [CNT_W-1:0] phase_cnt;
  logic             phase_end;
  seq_state_t       next_state;

  assign phase_end = (phase_cnt == CNT_W'(`MTX_SYNC_LEN - 1));

  always_comb begin
    next_state = state;
    case (state)
      SEQ_LEAD: begin
        if (phase_end) begin
          next_state = SEQ_MARK;
        end
      end
      SEQ_MARK: begin
        if (phase_end) begin
          next_state = SEQ_BLANK;
        end
      end
      SEQ_BLANK: begin
        if (phase_end) begin
          next_state = SEQ_TAIL;
        end
      end
      SEQ_TAIL: begin
        if (phase_end) begin
          next_state = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (frame_done) begin
          next_state = SEQ_LEAD;  // New frame, sync again
        end
      end
      default: begin
        next_state = SEQ_LEAD;
      end
    endcase
  end

  // Outputs follow the state they will belong to, so they change with it
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= SEQ_LEAD;
      phase_cnt  <= '0;
      gen_hold   <= 1'b1;
      hop_hold   <= 1'b1;
      blank      <= 1'b0;
      sync_level <= 1'b0;
    end else begin
      state <= next_state;
      if (phase_end || state == SEQ_RUN) begin
        phase_cnt <= '0;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
      gen_hold   <= next_state inside {SEQ_LEAD, SEQ_MARK, SEQ_BLANK};
      hop_hold   <= next_state inside {SEQ_LEAD, SEQ_MARK};
      blank      <= (next_state == SEQ_BLANK);
      sync_level <= next_state inside {SEQ_MARK, SEQ_BLANK};
    end
  end

endmodule

`default_nettype wire

//--- mtx_sig.sv
`timescale 1ns/1ns
`default_nettype none

`include "mtx_params.svh"

module mtx_sig (
  input  wire               clk,
  input  wire               reset,
  input  wire               gen_hold,
  output mtx_pkg::sample_t  sin,
  output mtx_pkg::sample_t  cos,
  output mtx_pkg::phase_t   phase,
  output mtx_pkg::symb_t    symb_idx,
  output logic              frame_done
);

  import mtx_pkg::*;

  localparam int SAMP_W = $clog2(`MTX_NSIG);

  // round(32767 * sin(2*pi*k/64))
  localparam sample_t SIN_LUT [64] = '{
         0,   3212,   6393,   9512,  12539,  15446,  18204,  20787,
     23170,  25329,  27245,  28898,  30273,  31356,  32137,  32609,
     32767,  32609,  32137,  31356,  30273,  28898,  27245,  25329,
     23170,  20787,  18204,  15446,  12539,   9512,   6393,   3212,
         0,  -3212,  -6393,  -9512, -12539, -15446, -18204, -20787,
    -23170, -25329, -27245, -28898, -30273, -31356, -32137, -32609,
    -32767, -32609, -32137, -31356, -30273, -28898, -27245, -25329,
    -23170, -20787, -18204, -15446, -12539,  -9512,  -6393,  -3212
  };

  phase_t            ph_inc;
  logic [SAMP_W-1:0] samp_cnt;
  logic              last_samp;
  logic              last_symb;
  logic [5:0]        sin_idx;
  logic [5:0]        cos_idx;

  assign last_samp  = (samp_cnt == SAMP_W'(`MTX_NSIG - 1));
  assign last_symb  = (symb_idx == symb_t'(`MTX_NSYMB - 1));
  assign frame_done = last_samp && last_symb;

  assign sin_idx = phase[`MTX_PHASE_W-1 -: 6];
  assign cos_idx = sin_idx + 6'd16;  // Quarter turn ahead, wraps at 64

  always_ff @(posedge clk) begin
    if (reset || gen_hold) begin
      phase    <= '0;
      ph_inc   <= `MTX_START_PH_INC;
      samp_cnt <= '0;
      symb_idx <= '0;
    end else begin
      phase    <= phase + ph_inc;
      samp_cnt <= samp_cnt + 1'b1;
      if (last_samp) begin
        samp_cnt <= '0;
        if (last_symb) begin
          symb_idx <= '0;
          ph_inc   <= `MTX_START_PH_INC;  // Frame wraps, phase keeps running
        end else begin
          symb_idx <= symb_idx + 1'b1;
          ph_inc   <= ph_inc + `MTX_DPH_INC;  // Next tone
        end
      end
    end
  end

  // Registered table read, one cycle behind the phase
  always_ff @(posedge clk) begin
    sin <= SIN_LUT[sin_idx];
    cos <= SIN_LUT[cos_idx];
  end

endmodule

`default_nettype wire

//--- hop_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mtx_params.svh"

module hop_ctrl (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   hop_hold,
  input  wire mtx_pkg::hop_word_t hop_word,
  output mtx_pkg::bit_cnt_t     bit_count,
  scan_if.driver                scan
);

  import mtx_pkg::*;

  localparam int TICK_W = $clog2(`MTX_SCAN_DIV);
  localparam bit_cnt_t LAST_BIT = bit_cnt_t'(`MTX_HOP_W - 1);

  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  logic [1:0]        half_ph;   // 0 setup, 1 phi, 2 gap, 3 phi_bar
  hop_word_t         shreg;
  logic              load_q;
  logic              shifting;

  assign tick     = (tick_cnt == TICK_W'(`MTX_SCAN_DIV - 1));
  assign shifting = ~hop_hold & ~load_q;

  always_ff @(posedge clk) begin
    if (reset || hop_hold) begin
      tick_cnt  <= '0;
      half_ph   <= '0;
      shreg     <= hop_word;  // Held shifter keeps the next word ready
      bit_count <= '0;
      load_q    <= 1'b0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick) begin
        if (load_q) begin
          load_q    <= 1'b0;
          shreg     <= hop_word;  // Start the next pass
          bit_count <= '0;
        end else begin
          half_ph <= half_ph + 2'd1;
          if (half_ph == 2'd3) begin
            shreg     <= {shreg[`MTX_HOP_W-2:0], 1'b0};
            bit_count <= bit_count + 1'b1;
            load_q    <= (bit_count == LAST_BIT);
          end
        end
      end
    end
  end

  // half_ph rests at 0 while held or loading, so the clocks stay low then
  assign scan.scan_id = shifting;
  assign scan.phi     = (half_ph == 2'd1);
  assign scan.phi_bar = (half_ph == 2'd3);
  assign scan.data    = shifting & shreg[`MTX_HOP_W-1];
  assign scan.load    = load_q;

endmodule

`default_nettype wire

//--- gpio_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mtx_params.svh"

module gpio_ctrl (
  input  wire                 clk,
  input  wire                 reset,
  scan_if.pins                scan,
  input  wire                 sync_level,
  input  wire                 tx_on,
  input  wire mtx_pkg::gpio_t gpio_in,
  output mtx_pkg::gpio_t      gpio_out,
  output mtx_pkg::gpio_t      gpio_ddr,
  output mtx_pkg::gpio_t      gpio_sync
);

  import mtx_pkg::*;

  localparam gpio_t OUT_MASK = `MTX_SYNC_MASK | `MTX_LOAD_MASK | `MTX_DATA_MASK |
                               `MTX_PHIB_MASK | `MTX_PHI_MASK | `MTX_ID_MASK |
                               `MTX_TX_MASK;

  gpio_t out_next;
  gpio_t in_meta;
  gpio_t in_sync;

  assign out_next = ({`MTX_GPIO_W{sync_level}}   & `MTX_SYNC_MASK) |
                    ({`MTX_GPIO_W{scan.load}}    & `MTX_LOAD_MASK) |
                    ({`MTX_GPIO_W{scan.data}}    & `MTX_DATA_MASK) |
                    ({`MTX_GPIO_W{scan.phi_bar}} & `MTX_PHIB_MASK) |
                    ({`MTX_GPIO_W{scan.phi}}     & `MTX_PHI_MASK)  |
                    ({`MTX_GPIO_W{scan.scan_id}} & `MTX_ID_MASK)   |
                    ({`MTX_GPIO_W{tx_on}}        & `MTX_TX_MASK);

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
      in_meta  <= '0;
      in_sync  <= '0;
    end else begin
      gpio_out <= out_next;
      in_meta  <= gpio_in;  // Header inputs are asynchronous
      in_sync  <= in_meta;
    end
  end

  assign gpio_ddr  = OUT_MASK;  // Every driven pin is an output
  assign gpio_sync = in_sync & `MTX_IN_MASK;

endmodule

`default_nettype wire

//--- mtx_top.sv
`timescale 1ns/1ns
`default_nettype none

module mtx_top (
  input  wire                     clk,
  input  wire                     reset,
  input  wire mtx_pkg::hop_word_t tx_bits,
  input  wire mtx_pkg::gpio_t     fp_gpio_in,
  output mtx_pkg::sample_t        itx,
  output mtx_pkg::sample_t        qtx,
  output logic                    tx_valid,
  output mtx_pkg::gpio_t          fp_gpio_out,
  output mtx_pkg::gpio_t          fp_gpio_ddr,
  output mtx_pkg::gpio_t          gpio_status,
  output mtx_pkg::bit_cnt_t       ntx_bits_cnt,
  output mtx_pkg::symb_t          symb_n,
  output logic                    tx_trig
);

  import mtx_pkg::*;

  logic    gen_hold;
  logic    hop_hold;
  logic    blank;
  logic    sync_level;
  logic    frame_done;
  sample_t sin_s;
  sample_t cos_s;

  scan_if u_scan ();

  mtx_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .frame_done (frame_done),
    .gen_hold   (gen_hold),
    .hop_hold   (hop_hold),
    .blank      (blank),
    .sync_level (sync_level),
    .state      ()
  );

  mtx_sig u_sig (
    .clk        (clk),
    .reset      (reset),
    .gen_hold   (gen_hold),
    .sin        (sin_s),
    .cos        (cos_s),
    .phase      (),
    .symb_idx   (symb_n),
    .frame_done (frame_done)
  );

  hop_ctrl u_hop (
    .clk       (clk),
    .reset     (reset),
    .hop_hold  (hop_hold),
    .hop_word  (tx_bits),
    .bit_count (ntx_bits_cnt),
    .scan      (u_scan.driver)
  );

  gpio_ctrl u_gpio (
    .clk        (clk),
    .reset      (reset),
    .scan       (u_scan.pins),
    .sync_level (sync_level),
    .tx_on      (~blank),
    .gpio_in    (fp_gpio_in),
    .gpio_out   (fp_gpio_out),
    .gpio_ddr   (fp_gpio_ddr),
    .gpio_sync  (gpio_status)
  );

  // Silent during the blank phase
  assign itx      = blank ? '0 : cos_s;
  assign qtx      = blank ? '0 : sin_s;
  assign tx_valid = ~blank;
  assign tx_trig  = gen_hold;

endmodule

`default_nettype wire

//--- mtx_sva.sv
`timescale 1ns/1ns
`default_nettype none

// Checks on the sequencer and the scan shifter
module mtx_sva (
  input wire                      clk,
  input wire                      reset,
  input wire mtx_pkg::seq_state_t state,
  input wire                      phase_end,
  input wire                      frame_done,
  input wire                      blank,
  input wire                      hop_hold,
  input wire                      phi,
  input wire                      phi_bar
);

  // Two-phase scan clocks never overlap
  assert property (@(posedge clk) disable iff (reset) !(phi && phi_bar))
    else $error("phi and phi_bar high together");

  assert property (@(posedge clk) disable iff (reset) blank |-> !hop_hold)
    else $error("Shifter still held during blank");

  // State moves only at the end of a sync phase or on a frame restart
  assert property (@(posedge clk) disable iff (reset)
                   (state != $past(state)) |-> $past(phase_end || frame_done))
    else $error("Sequencer state changed without a cause");

endmodule

bind mtx_top mtx_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .state      (u_ctrl.state),
  .phase_end  (u_ctrl.phase_end),
  .frame_done (frame_done),
  .blank      (blank),
  .hop_hold   (hop_hold),
  .phi        (u_scan.phi),
  .phi_bar    (u_scan.phi_bar)
);

`default_nettype wire

//--- tb_mtx.sv
`timescale 1ns/1ns
`default_nettype none

`include "mtx_params.svh"

module tb_mtx;

  import mtx_pkg::*;

  localparam int  BURST_CYC = 4 * `MTX_SYNC_LEN + `MTX_NSIG * `MTX_NSYMB;
  localparam int  LIMIT     = 2 * BURST_CYC + 200;
  localparam int  BIT_CYC   = 4 * `MTX_SCAN_DIV;
  localparam int  PASS_CYC  = `MTX_HOP_W * BIT_CYC + `MTX_SCAN_DIV;  // Shift then load
  localparam real PI        = 3.14159265358979;

  logic      clk;
  logic      reset;
  hop_word_t tx_bits;
  gpio_t     fp_gpio_in;
  sample_t   itx, qtx;
  logic      tx_valid, tx_trig;
  gpio_t     fp_gpio_out, fp_gpio_ddr, gpio_status;
  bit_cnt_t  ntx_bits_cnt;
  symb_t     symb_n;

  // Reference model, state of the current cycle
  seq_state_t m_state;
  int         m_cnt, m_samp, m_symb;
  phase_t     m_phase;
  logic [5:0] m_k;       // Table index held in the sample registers
  int         m_hop_t;   // Cycles since the shifter was released
  hop_word_t  m_word;
  gpio_t      m_pins, m_in1, m_in2;

  logic e_gen_hold, e_hop_hold, e_blank, e_sync, e_fdone;
  logic e_load, e_id, e_phi, e_phib, e_data;
  int   e_bits;

  int          err_cnt, check_cnt, end_err, cycle_cnt;
  int          bursts, releases, phi_pulses;
  logic        trig_q, phi_q, rise;

  mtx_top u_mtx_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic sample_t lut_sample(input logic [5:0] k, input bit use_cos);
    real ang;
    real val;
    ang = 2.0 * PI * k / 64.0;
    val = use_cos ? 32767.0 * $cos(ang) : 32767.0 * $sin(ang);
    if (val >= 0.0) begin
      return sample_t'($rtoi(val + 0.5));
    end
    return sample_t'(-$rtoi(0.5 - val));
  endfunction

  // Header word from the pin map
  function automatic gpio_t pin_word(input logic sync, input logic tx_on, input logic id,
                                     input logic data, input logic phi, input logic phib,
                                     input logic load);
    gpio_t w;
    w     = '0;
    w[0]  = sync;
    w[2]  = load;
    w[4]  = data;
    w[6]  = phib;
    w[8]  = phi;
    w[10] = id;
    w[11] = tx_on;
    return w;
  endfunction

  task automatic check_value(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic reset_model();
    m_state = SEQ_LEAD;
    m_cnt   = 0;
    m_samp  = 0;
    m_symb  = 0;
    m_phase = '0;
    m_k     = '0;
    m_hop_t = 0;
    m_word  = tx_bits;
    m_pins  = '0;
    m_in1   = '0;
    m_in2   = '0;
  endtask

  task automatic decode_model();
    int half;
    int bit_i;
    half       = (m_hop_t / `MTX_SCAN_DIV) % 4;
    bit_i      = m_hop_t / BIT_CYC;
    e_gen_hold = m_state inside {SEQ_LEAD, SEQ_MARK, SEQ_BLANK};
    e_hop_hold = m_state inside {SEQ_LEAD, SEQ_MARK};
    e_blank    = (m_state == SEQ_BLANK);
    e_sync     = m_state inside {SEQ_MARK, SEQ_BLANK};
    e_fdone    = (m_samp == `MTX_NSIG - 1) && (m_symb == `MTX_NSYMB - 1);
    e_load     = (m_hop_t >= `MTX_HOP_W * BIT_CYC);
    e_id       = !e_hop_hold && !e_load;
    e_phi      = (half == 1);
    e_phib     = (half == 3);
    e_data     = e_id ? m_word[`MTX_HOP_W - 1 - bit_i] : 1'b0;
    e_bits     = e_load ? `MTX_HOP_W : bit_i;
  endtask

  task automatic compare_outputs();
    check_value("itx", itx, e_blank ? 0 : lut_sample(m_k, 1'b1));
    check_value("qtx", qtx, e_blank ? 0 : lut_sample(m_k, 1'b0));
    check_value("tx_valid", tx_valid, !e_blank);
    check_value("tx_trig", tx_trig, e_gen_hold);
    check_value("symb_n", symb_n, m_symb);
    check_value("ntx_bits_cnt", ntx_bits_cnt, e_bits);
    check_value("fp_gpio_out", fp_gpio_out, m_pins);
    check_value("fp_gpio_ddr", fp_gpio_ddr, 12'hD55);
    check_value("gpio_status", gpio_status, m_in2 & 12'h022);
  endtask

  task automatic advance_model();
    m_pins = pin_word(e_sync, !e_blank, e_id, e_data, e_phi, e_phib, e_load);
    m_in2  = m_in1;
    m_in1  = fp_gpio_in;
    m_k    = m_phase[`MTX_PHASE_W-1 -: 6];
    if (e_gen_hold) begin
      m_phase = '0;
      m_samp  = 0;
      m_symb  = 0;
    end else begin
      m_phase = m_phase + phase_t'(`MTX_START_PH_INC + m_symb * `MTX_DPH_INC);
      if (m_samp == `MTX_NSIG - 1) begin
        m_samp = 0;
        m_symb = (m_symb == `MTX_NSYMB - 1) ? 0 : m_symb + 1;
      end else begin
        m_samp++;
      end
    end
    if (e_hop_hold || m_hop_t == PASS_CYC - 1) begin
      m_hop_t = 0;
      m_word  = tx_bits;   // Word the shifter captures at the next edge
    end else begin
      m_hop_t++;
    end
    if (m_state == SEQ_RUN) begin
      m_cnt = 0;
      if (e_fdone) begin
        m_state = SEQ_LEAD;
      end
    end else if (m_cnt == `MTX_SYNC_LEN - 1) begin
      m_cnt   = 0;
      m_state = seq_state_t'(m_state + 1);
    end else begin
      m_cnt++;
    end
  endtask

  always @(negedge clk) begin
    if (reset) begin
      reset_model();
    end else begin
      decode_model();
      compare_outputs();
      advance_model();
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt + end_err);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9570e076));
    reset      = 1'b1;
    tx_bits    = hop_word_t'($urandom);
    fp_gpio_in = '0;
    trig_q     = 1'b1;
    phi_q      = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    while (releases < 3) begin   // Third generator release ends the run
      @(negedge clk);
      rise = tx_trig && !trig_q;
      if (rise) begin
        bursts++;
      end
      if (!tx_trig && trig_q) begin
        releases++;
      end
      if (fp_gpio_out[8] && !phi_q) begin
        phi_pulses++;
      end
      trig_q = tx_trig;
      phi_q  = fp_gpio_out[8];
      @(posedge clk);
      fp_gpio_in <= gpio_t'($urandom);
      if (rise) begin
        tx_bits <= hop_word_t'($urandom);
      end
    end
    repeat (20) @(posedge clk);
    assert (bursts == 2) else begin
      end_err++;
      $display("Expected 2 frame restarts but saw %0d", bursts);
    end
    assert (phi_pulses > 0) else begin
      end_err++;
      $display("No phi pulse ever reached the header");
    end
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt + end_err);
    if (err_cnt + end_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
mtx_pkg.sv
scan_if.sv
mtx_ctrl.sv
mtx_sig.sv
hop_ctrl.sv
gpio_ctrl.sv
mtx_top.sv
mtx_sva.sv
tb_mtx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mtx
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
